//--- common/fix_pkg.sv
// FIX checksum definitions

package fix_pkg;

	// ******************************************************************
	// Widths
	// ******************************************************************

	// Byte lanes and the checksum itself are one octet wide
	localparam int BYTE_W = 8;

	// ******************************************************************
	// Protocol characters
	// ******************************************************************

	// Field delimiter, ends every tag=value pair
	localparam logic [BYTE_W-1:0] FIX_SOH = 8'h01;

	localparam logic [BYTE_W-1:0] ASCII_ZERO = 8'h30;  // Lowest decimal digit
	localparam logic [BYTE_W-1:0] ASCII_NINE = 8'h39;  // Highest decimal digit

	// The trailer tag is "10=" and has to start a field
	localparam logic [BYTE_W-1:0] TAG_CHAR_ONE  = 8'h31;
	localparam logic [BYTE_W-1:0] TAG_CHAR_ZERO = 8'h30;
	localparam logic [BYTE_W-1:0] TAG_EQUALS    = 8'h3D;

	// ******************************************************************
	// Trailer format
	// ******************************************************************

	// The checksum value is always sent as exactly three digits, zero padded
	localparam logic [1:0] CHECKSUM_DIGITS = 2'd3;

endpackage

//--- common/fix_byte_if.sv
// FIX annotated byte stream
`timescale 1ns/1ps

interface fix_byte_if;
	import fix_pkg::*;

	logic [BYTE_W-1:0] data;  // Message byte
	logic              valid;  // Byte strobe, qualifies everything else
	logic              first;  // First byte of a message
	logic              last;  // Last byte of a message

	// One cycle on the "=" of a trailer tag found at a field start
	logic              tag_hit;

	// High from the byte after tag_hit up to the last byte
	logic              in_trailer;

	modport src (
		output data,
		output valid,
		output first,
		output last,
		output tag_hit,
		output in_trailer
	);

	modport dst (
		input data,
		input valid,
		input first,
		input last,
		input tag_hit,
		input in_trailer
	);

endinterface

//--- rtl/fix_field_tracker.sv
// FIX trailer field tracker
`timescale 1ns/1ps

module fix_field_tracker (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [fix_pkg::BYTE_W-1:0] byte_i,
	input  logic                       valid_i,
	input  logic                       first_i,
	input  logic                       last_i,
	fix_byte_if.src                    stream
);
	import fix_pkg::*;

	// ******************************************************************
	// Tag matching
	// ******************************************************************

	logic prev_soh_q;  // Previous valid byte was a delimiter
	logic saw_one_q;  // "1" seen at a field start
	logic saw_ten_q;  // "10" seen at a field start
	logic trailer_q;  // Trailer tag already passed in this message

	logic field_start;
	logic hit;
	logic trailer_now;

	always_comb begin
		// A field starts on the first byte of a message or right after SOH
		field_start = first_i | prev_soh_q;

		// The "=" completes the tag only if "10" came straight before it
		hit = saw_ten_q & ~first_i & (byte_i == TAG_EQUALS);

		// A new message never continues the trailer of the one before
		trailer_now = trailer_q & ~first_i;
	end

	// Match progress only moves on valid bytes, so gaps are transparent
	always_ff @(posedge clk) begin
		if (rst) begin
			prev_soh_q <= 1'b0;
			saw_one_q  <= 1'b0;
			saw_ten_q  <= 1'b0;
			trailer_q  <= 1'b0;
		end else if (valid_i) begin
			prev_soh_q <= (byte_i == FIX_SOH);
			saw_one_q  <= field_start & (byte_i == TAG_CHAR_ONE);
			saw_ten_q  <= saw_one_q & ~first_i & (byte_i == TAG_CHAR_ZERO);

			// Set by the tag, dropped once the message ends
			trailer_q  <= ~last_i & (hit | trailer_now);
		end
	end

	// ******************************************************************
	// Output stream register
	// ******************************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			stream.valid      <= 1'b0;
			stream.first      <= 1'b0;
			stream.last       <= 1'b0;
			stream.tag_hit    <= 1'b0;
			stream.in_trailer <= 1'b0;
		end else begin
			stream.valid      <= valid_i;
			stream.first      <= valid_i & first_i;
			stream.last       <= valid_i & last_i;
			stream.tag_hit    <= valid_i & hit;
			stream.in_trailer <= valid_i & trailer_now;  // Bytes after the tag
		end
	end

	// The byte itself, loaded with every valid input byte
	always_ff @(posedge clk) begin
		if (valid_i) begin
			stream.data <= byte_i;
		end
	end

endmodule

//--- checksum/ascii2int.sv
// ASCII trailer to integer
`timescale 1ns/1ps

module ascii2int (
	input  logic                       clk,
	input  logic                       rst,
	fix_byte_if.dst                    stream,
	output logic                       done_o,
	output logic [fix_pkg::BYTE_W-1:0] value_o,
	output logic                       err_o
);
	import fix_pkg::*;

	// Two extra bits hold up to three decimal digits, 999 at most
	logic [BYTE_W+1:0] acc_q;
	logic [1:0]        cnt_q;  // Digits taken so far
	logic              err_q;  // Bad byte seen in the trailer

	logic [BYTE_W+1:0] acc_base;
	logic [BYTE_W+1:0] acc_next;
	logic [BYTE_W+1:0] digit_val;
	logic [1:0]        cnt_base;
	logic [1:0]        cnt_next;
	logic              err_base;
	logic              err_next;
	logic              is_digit;
	logic              is_soh;
	logic              final_err;

	always_comb begin
		// A first byte starts from a clean state
		acc_base = stream.first ? '0 : acc_q;
		cnt_base = stream.first ? '0 : cnt_q;
		err_base = stream.first ? 1'b0 : err_q;

		is_digit  = (stream.data >= ASCII_ZERO) && (stream.data <= ASCII_NINE);
		is_soh    = (stream.data == FIX_SOH);
		digit_val = (BYTE_W + 2)'(stream.data - ASCII_ZERO);

		acc_next = acc_base;
		cnt_next = cnt_base;
		err_next = err_base;

		if (stream.in_trailer) begin
			if (is_digit) begin
				if (cnt_base == CHECKSUM_DIGITS) begin
					err_next = 1'b1;  // More digits than the format allows
				end else begin
					acc_next = acc_base * (BYTE_W + 2)'(10) + digit_val;
					cnt_next = cnt_base + 2'd1;
				end
			end else if (!(stream.last && is_soh)) begin
				// Only the closing SOH may follow the digits
				err_next = 1'b1;
			end
		end

		// Whole trailer checks, meaningful on the last byte only
		final_err = err_next | ~is_soh | (cnt_next != CHECKSUM_DIGITS) |
			(|acc_next[BYTE_W+1:BYTE_W]);  // Above 255
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt_q  <= '0;
			err_q  <= 1'b0;
			done_o <= 1'b0;
			err_o  <= 1'b0;
		end else begin
			done_o <= stream.valid & stream.last;
			if (stream.valid) begin
				cnt_q <= cnt_next;
				err_q <= err_next;
			end
			if (stream.valid && stream.last) begin
				err_o <= final_err;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (stream.valid) begin
			acc_q <= acc_next;
		end
		if (stream.valid && stream.last) begin
			value_o <= acc_next[BYTE_W-1:0];  // Upper bits are covered by err_o
		end
	end

endmodule

//--- checksum/checksum.sv
// FIX message checksum
`timescale 1ns/1ps

module checksum (
	input  logic                       clk,
	input  logic                       rst,
	fix_byte_if.dst                    stream,
	output logic [fix_pkg::BYTE_W-1:0] checksum_o,
	output logic                       match_o,
	output logic                       format_err_o,
	output logic                       done_o
);
	import fix_pkg::*;

	logic [BYTE_W-1:0] sum_q;  // Running sum of the message so far
	logic [BYTE_W-1:0] delim_q;  // Sum up to and including the latest SOH
	logic [BYTE_W-1:0] frozen_q;  // Computed checksum of this message

	logic [BYTE_W-1:0] sum_next;
	logic [BYTE_W-1:0] delim_base;

	// Received trailer from the converter
	logic              asc_done;
	logic [BYTE_W-1:0] asc_value;
	logic              asc_err;

	// ******************************************************************
	// Running sum
	// ******************************************************************

	always_comb begin
		// Overflow past 8 bits drops out, which gives the modulo 256
		sum_next   = (stream.first ? '0 : sum_q) + stream.data;
		delim_base = stream.first ? '0 : delim_q;
	end

	always_ff @(posedge clk) begin
		if (stream.valid) begin
			sum_q <= sum_next;

			if (stream.data == FIX_SOH) begin
				delim_q <= sum_next;  // The SOH itself is part of the sum
			end else begin
				delim_q <= delim_base;
			end

			// The tag bytes "10=" are not summed, so take the sum at the
			// delimiter in front of them
			if (stream.tag_hit) begin
				frozen_q <= delim_base;
			end else if (stream.first) begin
				frozen_q <= '0;
			end
		end
	end

	// ******************************************************************
	// Trailer value
	// ******************************************************************

	ascii2int ascii2int_i (
		.clk     (clk),
		.rst     (rst),
		.stream  (stream),
		.done_o  (asc_done),
		.value_o (asc_value),
		.err_o   (asc_err)
	);

	// ******************************************************************
	// Result
	// ******************************************************************

	// frozen_q is still this message's value here even when the next
	// message has already started, since a tag needs three bytes
	always_ff @(posedge clk) begin
		if (rst) begin
			done_o       <= 1'b0;
			checksum_o   <= '0;
			match_o      <= 1'b0;
			format_err_o <= 1'b0;
		end else begin
			done_o <= asc_done;
			if (asc_done) begin
				checksum_o   <= frozen_q;
				format_err_o <= asc_err;
				match_o      <= ~asc_err & (asc_value == frozen_q);
			end
		end
	end

endmodule

//--- rtl/fix_checksum_top.sv
// FIX checksum checker top
`timescale 1ns/1ps

module fix_checksum_top (
	input  logic                       clk,
	input  logic                       rst,

	// Incoming message bytes, one per valid cycle
	input  logic [fix_pkg::BYTE_W-1:0] byte_i,
	input  logic                       valid_i,
	input  logic                       first_i,
	input  logic                       last_i,

	// Per message result, held until the next done_o
	output logic [fix_pkg::BYTE_W-1:0] checksum_o,
	output logic                       match_o,
	output logic                       format_err_o,
	output logic                       done_o
);

	// ******************************************************************
	// Annotated byte stream between tracker and checksum
	// ******************************************************************

	fix_byte_if stream ();

	// Finds the "10=" trailer tag and marks the bytes after it
	fix_field_tracker fix_field_tracker_i (
		.clk     (clk),
		.rst     (rst),
		.byte_i  (byte_i),
		.valid_i (valid_i),
		.first_i (first_i),
		.last_i  (last_i),
		.stream  (stream.src)
	);

	// ******************************************************************
	// Sum and compare
	// ******************************************************************

	checksum checksum_i (
		.clk          (clk),
		.rst          (rst),
		.stream       (stream.dst),
		.checksum_o   (checksum_o),
		.match_o      (match_o),
		.format_err_o (format_err_o),
		.done_o       (done_o)  // Three cycles after the last byte
	);

endmodule

//--- dv/fix_checksum_tb.sv
// FIX checksum testbench
`timescale 1ns/1ps

module fix_checksum_tb;

	logic       clk;
	logic       rst;
	logic [7:0] byte_i;
	logic       valid_i;
	logic       first_i;
	logic       last_i;
	logic [7:0] checksum_o;
	logic       match_o;
	logic       format_err_o;
	logic       done_o;

	// Messages and their expected results as read from the data file
	logic [7:0] msg_bytes[$];
	int         msg_len[$];
	logic [7:0] exp_sum[$];
	logic [7:0] exp_match[$];
	logic [7:0] exp_err[$];
	logic [7:0] msg_gaps[$];

	int last_cyc_q[$];  // Cycles at which a last byte was sampled
	int result_idx;  // Next message whose result is due
	int cyc;
	int limit;
	int errors;
	int checks;
	int late;

	fix_checksum_top fix_checksum_top_i (
		.clk          (clk),
		.rst          (rst),
		.byte_i       (byte_i),
		.valid_i      (valid_i),
		.first_i      (first_i),
		.last_i       (last_i),
		.checksum_o   (checksum_o),
		.match_o      (match_o),
		.format_err_o (format_err_o),
		.done_o       (done_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ******************************************************************
	// Helpers
	// ******************************************************************

	task automatic check_value(input string name, input logic [7:0] got,
			input logic [7:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("** Error %s: got %h, expected %h", name, got, want);
		end
	endtask

	// Tokens are "#" comments, "M" headers, hex bytes and "E" end markers
	task automatic read_messages();
		int            fd;
		int            start;
		string         tok;
		logic [1023:0] skip_line;
		logic [7:0]    s;
		logic [7:0]    m;
		logic [7:0]    e;
		logic [7:0]    g;
		fd = $fopen("dv/fix_input.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open dv/fix_input.txt, there is no stimulus to run");
		end else begin
			start = 0;
			while ($fscanf(fd, "%s", tok) == 1) begin
				if (tok == "#") begin
					void'($fgets(skip_line, fd));  // Rest of a comment line
				end else if (tok == "M") begin
					if ($fscanf(fd, "%h %h %h %h", s, m, e, g) != 4) begin
						errors++;
						$display("A message header in the data file is incomplete");
					end
					exp_sum.push_back(s);
					exp_match.push_back(m);
					exp_err.push_back(e);
					msg_gaps.push_back(g);
					start = msg_bytes.size();
				end else if (tok == "E") begin
					msg_len.push_back(msg_bytes.size() - start);
				end else begin
					msg_bytes.push_back(8'(tok.atohex()));
				end
			end
			$fclose(fd);
		end
		if (msg_len.size() == 0) begin
			errors++;
			$display("The data file holds no messages");
		end
	endtask

	task automatic send_byte(input logic [7:0] b, input logic first, input logic last);
		@(posedge clk);
		byte_i  <= b;
		valid_i <= 1'b1;
		first_i <= first;
		last_i  <= last;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			valid_i <= 1'b0;
			first_i <= 1'b0;
			last_i  <= 1'b0;
		end
	endtask

	task automatic send_message(input int pos, input int len, input logic gaps);
		for (int i = 0; i < len; i++) begin
			send_byte(msg_bytes[pos + i], i == 0, i == len - 1);
			if (gaps) begin
				idle_cycles(int'($urandom % 4));
			end
		end
	endtask

	// ******************************************************************
	// Stimulus
	// ******************************************************************

	initial begin
		int pos;
		rst     = 1'b1;
		byte_i  = 8'h00;
		valid_i = 1'b0;
		first_i = 1'b0;
		last_i  = 1'b0;
		errors     = 0;
		checks     = 0;
		cyc        = 0;
		result_idx = 0;
		limit      = 0;
		void'($urandom(30826));

		read_messages();
		limit = msg_bytes.size() * 4 + 16 + 50;  // Up to three idle cycles per byte

		repeat (16) @(posedge clk);
		rst <= 1'b0;
		repeat (2) @(posedge clk);

		// Outputs stay quiet until the first message completes
		check_value("done_o", 8'(done_o), 8'h00);
		check_value("match_o", 8'(match_o), 8'h00);
		check_value("format_err_o", 8'(format_err_o), 8'h00);
		check_value("checksum_o", checksum_o, 8'h00);

		pos = 0;
		for (int k = 0; k < msg_len.size(); k++) begin
			send_message(pos, msg_len[k], msg_gaps[k] != 8'h00);
			pos += msg_len[k];
		end
		idle_cycles(1);

		while (result_idx < msg_len.size()) begin
			@(posedge clk);
		end
		idle_cycles(8);  // Room for a stray done_o to show up

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// ******************************************************************
	// Result monitor and watchdog
	// ******************************************************************

	always @(posedge clk) begin
		cyc++;
		if (limit > 0 && cyc >= limit) begin
			$display("Timeout after %0d cycles, results are still outstanding", cyc);
			$display("Something failed");
			$finish;
		end else if (!rst) begin
			if (valid_i && last_i) begin
				last_cyc_q.push_back(cyc);
			end
			if (done_o) begin
				if (last_cyc_q.size() == 0 || result_idx >= msg_len.size()) begin
					errors++;
					$display("done_o pulsed at cycle %0d with no message waiting", cyc);
				end else begin
					late = cyc - last_cyc_q.pop_front();
					if (late != 3) begin
						errors++;
						$display("done_o of message %0d came %0d cycles after its last byte",
							result_idx, late);
					end
					check_value("checksum_o", checksum_o, exp_sum[result_idx]);
					check_value("match_o", 8'(match_o), exp_match[result_idx]);
					check_value("format_err_o", 8'(format_err_o), exp_err[result_idx]);
					result_idx++;
				end
			end else if (last_cyc_q.size() > 0 && cyc > last_cyc_q[0] + 3) begin
				errors++;
				$display("done_o never came for message %0d", result_idx);
				void'(last_cyc_q.pop_front());
				result_idx++;
			end
		end
	end

endmodule

//--- dv/fix_input.txt
# M <checksum> <match> <format_err> <gaps> gives the expected results in hex, gaps 1 = idle cycles
# The message bytes in hex follow, and E closes the message
# Valid trailers, back to back
M 33 1 0 0
38 3D 46 49 58 01 33 35 3D 30 01 31 30 3D 30 35 31 01 E
M 47 1 0 0
38 3D 46 49 58 01 33 35 3D 44 01 31 30 3D 30 37 31 01 E
# Well formed but wrong value
M 33 0 0 1
38 3D 46 49 58 01 33 35 3D 30 01 31 30 3D 30 35 32 01 E
# Non-digit in the trailer
M 33 0 1 1
38 3D 46 49 58 01 33 35 3D 30 01 31 30 3D 30 41 31 01 E
# Two digits only
M 33 0 1 0
38 3D 46 49 58 01 33 35 3D 30 01 31 30 3D 35 31 01 E
# Four digits
M 33 0 1 1
38 3D 46 49 58 01 33 35 3D 30 01 31 30 3D 30 30 35 31 01 E
# Value 300 does not fit a byte
M 33 0 1 0
38 3D 46 49 58 01 33 35 3D 30 01 31 30 3D 33 30 30 01 E
# Last byte is not SOH
M 33 0 1 1
38 3D 46 49 58 01 33 35 3D 30 01 31 30 3D 30 35 31 E
# No trailer field at all
M 00 0 1 0
38 3D 46 49 58 01 33 35 3D 30 01 E
# Tag 110 must not be taken for the trailer
M 62 1 0 1
38 3D 46 49 58 01 31 31 30 3D 35 01 31 30 3D 30 39 38 01 E

//--- src.f
common/fix_pkg.sv
common/fix_byte_if.sv
rtl/fix_field_tracker.sv
checksum/ascii2int.sv
checksum/checksum.sv
rtl/fix_checksum_top.sv
dv/fix_checksum_tb.sv

//--- Makefile
# Verilator simulation of the FIX checksum checker

.PHONY: sim clean

sim:
	verilator --binary -f src.f --top-module fix_checksum_tb -o fix_sim
	out="$$(./obj_dir/fix_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
